/* source/dsp_route_pkg.sv */
package dsp_route_pkg;

   // sample and select widths
   localparam int DAT_W       = 14;             // signed sample
   localparam int SEL_W       = 4;              // source code, bus index field
   localparam int SUM_W       = DAT_W + SEL_W;  // room for 16 full-scale samples
   localparam int N_CH        = 2 ** SEL_W;     // adder tree inputs, zero padded
   localparam int SUM_LATENCY = 5;              // gate+pair, 3 tree levels, clamp

   // table sizes above N_SLOTS
   localparam int N_EXTRA_SRC  = 6;  // gen1/2, adc a/b, dac a/b
   localparam int N_EXTRA_SINK = 4;  // scope1/2, pwm0/1
   localparam int N_EXTRA_DIR  = 2;  // gen1/2 direct outputs

   // source codes relative to N_SLOTS
   localparam int SRC_ADC_A = 2;
   localparam int SRC_ADC_B = 3;

   localparam logic [SEL_W-1:0] SRC_NONE = SEL_W'(15);  // sink reads zero

   // destination of a direct output, bit0 = dac a, bit1 = dac b
   typedef enum logic [1:0] {
      OUT_OFF  = 2'd0,
      OUT_A    = 2'd1,
      OUT_B    = 2'd2,
      OUT_BOTH = 2'd3
   } out_sel_e;

   // register offsets, address bits 15:0
   typedef enum logic [15:0] {
      OFF_INSEL  = 16'h0000,
      OFF_OUTSEL = 16'h0004,
      OFF_SAT    = 16'h0008,
      OFF_SIGNAL = 16'h0010
   } reg_off_e;

   // clamp limits of the dac sums
   localparam logic signed [SUM_W-1:0] DAT_MAX = SUM_W'(2 ** (DAT_W - 1) - 1);
   localparam logic signed [SUM_W-1:0] DAT_MIN = -DAT_MAX - 1;

endpackage

/* source/dsp_route_regs.sv */
module dsp_route_regs
   import dsp_route_pkg::*;
#(
   parameter int N_SLOTS = 8
) (
   input  logic                                   clk_i,
   input  logic                                   rstn_i,
   // register bus
   input  logic [31:0]                            sys_addr_i,
   input  logic [31:0]                            sys_wdata_i,
   input  logic                                   sys_wen_i,
   input  logic                                   sys_ren_i,
   output logic [31:0]                            sys_rdata_o,
   output logic                                   sys_ack_o,
   // status from the datapath
   input  logic [(N_SLOTS+N_EXTRA_SRC)*DAT_W-1:0] src_dat_i,   // all sources, code order
   input  logic                                   sat_a_i,
   input  logic                                   sat_b_i,
   // routing and mixing setup
   output logic [(N_SLOTS+N_EXTRA_SINK)*SEL_W-1:0]         in_sel_o,
   output logic [(N_SLOTS+N_EXTRA_DIR)*$bits(out_sel_e)-1:0] out_sel_o
);

   localparam int N_SRC  = N_SLOTS + N_EXTRA_SRC;
   localparam int N_SINK = N_SLOTS + N_EXTRA_SINK;
   localparam int N_DIR  = N_SLOTS + N_EXTRA_DIR;
   localparam int OSEL_W = $bits(out_sel_e);

   logic [SEL_W-1:0] in_sel_q  [N_SINK];  // source code per sink
   out_sel_e         out_sel_q [N_DIR];   // dac destination per direct source

   logic [SEL_W-1:0] idx;      // register index, addr 19:16
   reg_off_e         off;      // register offset
   logic             sys_en;   // any access
   logic [31:0]      rdata_d;

   assign idx    = sys_addr_i[16 +: SEL_W];
   assign off    = reg_off_e'(sys_addr_i[15:0]);
   assign sys_en = sys_wen_i | sys_ren_i;

   // setup registers, reset gives the default routing
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int k = 0; k < N_SLOTS; k++) begin
            in_sel_q[k] <= SEL_W'(N_SLOTS + SRC_ADC_A);  // slots listen to adc a
         end
         in_sel_q[N_SLOTS]     <= SEL_W'(N_SLOTS + SRC_ADC_A);  // scope 1
         in_sel_q[N_SLOTS + 1] <= SEL_W'(N_SLOTS + SRC_ADC_B);  // scope 2
         in_sel_q[N_SLOTS + 2] <= SRC_NONE;                     // pwm 0 off
         in_sel_q[N_SLOTS + 3] <= SRC_NONE;                     // pwm 1 off
         for (int k = 0; k < N_DIR; k++) begin
            out_sel_q[k] <= OUT_OFF;
         end
      end else if (sys_wen_i) begin
         // writes outside the table or at other offsets are dropped
         if (off == OFF_INSEL && idx < N_SINK) begin
            in_sel_q[idx] <= sys_wdata_i[SEL_W-1:0];
         end
         if (off == OFF_OUTSEL && idx < N_DIR) begin
            out_sel_q[idx] <= out_sel_e'(sys_wdata_i[OSEL_W-1:0]);
         end
      end
   end

   // read mux, zero for anything unmapped
   always_comb begin
      rdata_d = '0;
      case (off)
         OFF_INSEL: begin
            if (idx < N_SINK) begin
               rdata_d[SEL_W-1:0] = in_sel_q[idx];
            end
         end
         OFF_OUTSEL: begin
            if (idx < N_DIR) begin
               rdata_d[OSEL_W-1:0] = out_sel_q[idx];
            end
         end
         OFF_SAT:    rdata_d[1:0] = {sat_b_i, sat_a_i};  // live clamp flags
         OFF_SIGNAL: begin
            if (idx < N_SRC) begin
               rdata_d[DAT_W-1:0] = src_dat_i[idx*DAT_W +: DAT_W];  // raw bits, no sign ext
            end
         end
         default: ;
      endcase
   end

   // ack one cycle after every request, data in the same cycle
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         sys_ack_o <= 1'b0;
      end else begin
         sys_ack_o <= sys_en;
      end
   end

   always_ff @(posedge clk_i) begin
      if (sys_en) begin
         sys_rdata_o <= rdata_d;
      end
   end

   // flatten for the datapath
   for (genvar g = 0; g < N_SINK; g++) begin : g_in_sel
      assign in_sel_o[g*SEL_W +: SEL_W] = in_sel_q[g];
   end

   for (genvar g = 0; g < N_DIR; g++) begin : g_out_sel
      assign out_sel_o[g*OSEL_W +: OSEL_W] = out_sel_q[g];
   end

endmodule

/* source/signal_router.sv */
module signal_router
   import dsp_route_pkg::*;
#(
   parameter int N_SLOTS = 8
) (
   input  logic                                    clk_i,
   input  logic                                    rstn_i,
   // sources
   input  logic [N_SLOTS*DAT_W-1:0]                slot_dat_i,
   input  logic [DAT_W-1:0]                        asg1_i,
   input  logic [DAT_W-1:0]                        asg2_i,
   input  logic [DAT_W-1:0]                        adc_a_i,
   input  logic [DAT_W-1:0]                        adc_b_i,
   input  logic [DAT_W-1:0]                        dac_a_i,  // dac feedback
   input  logic [DAT_W-1:0]                        dac_b_i,
   input  logic [(N_SLOTS+N_EXTRA_SINK)*SEL_W-1:0] in_sel_i,
   // source table for readback
   output logic [(N_SLOTS+N_EXTRA_SRC)*DAT_W-1:0]  src_dat_o,
   // sinks
   output logic [N_SLOTS*DAT_W-1:0]                slot_in_o,
   output logic [DAT_W-1:0]                        scope1_o,
   output logic [DAT_W-1:0]                        scope2_o,
   output logic [DAT_W-1:0]                        pwm0_o,
   output logic [DAT_W-1:0]                        pwm1_o
);

   localparam int N_SRC  = N_SLOTS + N_EXTRA_SRC;
   localparam int N_SINK = N_SLOTS + N_EXTRA_SINK;

   logic [DAT_W-1:0] src_tab [N_CH];    // every 4 bit code, unused ones read zero
   logic [DAT_W-1:0] sink_q  [N_SINK];

   // code order: slots, gen1, gen2, adc a, adc b, dac a, dac b
   assign src_dat_o = {dac_b_i, dac_a_i, adc_b_i, adc_a_i, asg2_i, asg1_i, slot_dat_i};

   for (genvar c = 0; c < N_CH; c++) begin : g_tab
      if (c < N_SRC) begin : g_src
         assign src_tab[c] = src_dat_o[c*DAT_W +: DAT_W];
      end else begin : g_pad
         assign src_tab[c] = '0;  // covers SRC_NONE too
      end
   end

   // one register per sink
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int k = 0; k < N_SINK; k++) begin
            sink_q[k] <= '0;
         end
      end else begin
         for (int k = 0; k < N_SINK; k++) begin
            sink_q[k] <= src_tab[in_sel_i[k*SEL_W +: SEL_W]];
         end
      end
   end

   for (genvar s = 0; s < N_SLOTS; s++) begin : g_slot_in
      assign slot_in_o[s*DAT_W +: DAT_W] = sink_q[s];
   end

   assign scope1_o = sink_q[N_SLOTS];
   assign scope2_o = sink_q[N_SLOTS + 1];
   assign pwm0_o   = sink_q[N_SLOTS + 2];
   assign pwm1_o   = sink_q[N_SLOTS + 3];

endmodule

/* source/dac_sum_tree.sv */
module dac_sum_tree
   import dsp_route_pkg::*;
#(
   parameter int N_SLOTS = 8
) (
   input  logic                                               clk_i,
   input  logic                                               rstn_i,
   input  logic [N_SLOTS*DAT_W-1:0]                           slot_dat_i,
   input  logic [DAT_W-1:0]                                   asg1_i,
   input  logic [DAT_W-1:0]                                   asg2_i,
   input  logic [(N_SLOTS+N_EXTRA_DIR)*$bits(out_sel_e)-1:0] out_sel_i,
   output logic [DAT_W-1:0]                                   dac_a_o,
   output logic [DAT_W-1:0]                                   dac_b_o,
   output logic                                               sat_a_o,  // last sample clamped
   output logic                                               sat_b_o
);

   localparam int N_DIR  = N_SLOTS + N_EXTRA_DIR;
   localparam int OSEL_W = $bits(out_sel_e);
   localparam int LEVELS = SUM_LATENCY - 2;  // tree levels after the pair stage

   logic [N_DIR*DAT_W-1:0]   dir_flat;               // direct outputs in code order
   logic signed [SUM_W-1:0]  dir_ext [N_CH];          // sign extended, padded
   logic [1:0]               dir_en  [N_CH];          // per dac enable, bit0 = dac a
   logic signed [SUM_W-1:0]  lvl_q   [2][LEVELS+1][N_CH/2];  // [dac][level][node]
   logic [DAT_W-1:0]         dac_q   [2];
   logic                     sat_q   [2];

   assign dir_flat = {asg2_i, asg1_i, slot_dat_i};

   for (genvar c = 0; c < N_CH; c++) begin : g_dir
      if (c < N_DIR) begin : g_used
         out_sel_e sel;
         assign sel        = out_sel_e'(out_sel_i[c*OSEL_W +: OSEL_W]);
         assign dir_ext[c] = {{SEL_W{dir_flat[c*DAT_W + DAT_W - 1]}}, dir_flat[c*DAT_W +: DAT_W]};
         assign dir_en[c]  = {sel == OUT_B || sel == OUT_BOTH, sel == OUT_A || sel == OUT_BOTH};
      end else begin : g_pad
         assign dir_ext[c] = '0;
         assign dir_en[c]  = 2'b00;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int d = 0; d < 2; d++) begin
            for (int l = 0; l <= LEVELS; l++) begin
               for (int p = 0; p < N_CH / 2; p++) begin
                  lvl_q[d][l][p] <= '0;
               end
            end
            dac_q[d] <= '0;
            sat_q[d] <= 1'b0;
         end
      end else begin
         for (int d = 0; d < 2; d++) begin
            // gate per dac and add neighbours
            for (int p = 0; p < N_CH / 2; p++) begin
               lvl_q[d][0][p] <= (dir_en[2*p][d]   ? dir_ext[2*p]   : '0)
                               + (dir_en[2*p+1][d] ? dir_ext[2*p+1] : '0);
            end
            // halve the node count each level
            for (int l = 1; l <= LEVELS; l++) begin
               for (int p = 0; p < (N_CH >> (l + 1)); p++) begin
                  lvl_q[d][l][p] <= lvl_q[d][l-1][2*p] + lvl_q[d][l-1][2*p+1];
               end
            end
            // clamp to the dac range
            if (lvl_q[d][LEVELS][0] > DAT_MAX) begin
               dac_q[d] <= DAT_MAX[DAT_W-1:0];
               sat_q[d] <= 1'b1;
            end else if (lvl_q[d][LEVELS][0] < DAT_MIN) begin
               dac_q[d] <= DAT_MIN[DAT_W-1:0];
               sat_q[d] <= 1'b1;
            end else begin
               dac_q[d] <= lvl_q[d][LEVELS][0][DAT_W-1:0];
               sat_q[d] <= 1'b0;
            end
         end
      end
   end

   assign dac_a_o = dac_q[0];
   assign dac_b_o = dac_q[1];
   assign sat_a_o = sat_q[0];
   assign sat_b_o = sat_q[1];

endmodule

/* source/dsp_route_top.sv */
module dsp_route_top
   import dsp_route_pkg::*;
#(
   parameter int N_SLOTS = 8  // 1 to 8 processing slots
) (
   input  logic                     clk_i,
   input  logic                     rstn_i,
   // converters and generators
   input  logic [DAT_W-1:0]         adc_a_i,
   input  logic [DAT_W-1:0]         adc_b_i,
   input  logic [DAT_W-1:0]         asg1_i,
   input  logic [DAT_W-1:0]         asg2_i,
   output logic [DAT_W-1:0]         dac_a_o,
   output logic [DAT_W-1:0]         dac_b_o,
   // external processing slots
   input  logic [N_SLOTS*DAT_W-1:0] slot_dat_i,  // direct outputs of the slots
   output logic [N_SLOTS*DAT_W-1:0] slot_in_o,
   // scope and pwm taps
   output logic [DAT_W-1:0]         scope1_o,
   output logic [DAT_W-1:0]         scope2_o,
   output logic [DAT_W-1:0]         pwm0_o,
   output logic [DAT_W-1:0]         pwm1_o,
   // register bus
   input  logic [31:0]              sys_addr_i,
   input  logic [31:0]              sys_wdata_i,
   input  logic                     sys_wen_i,
   input  logic                     sys_ren_i,
   output logic [31:0]              sys_rdata_o,
   output logic                     sys_ack_o
);

   logic [(N_SLOTS+N_EXTRA_SINK)*SEL_W-1:0]           in_sel;
   logic [(N_SLOTS+N_EXTRA_DIR)*$bits(out_sel_e)-1:0] out_sel;
   logic [(N_SLOTS+N_EXTRA_SRC)*DAT_W-1:0]            src_dat;  // for signal readback
   logic                                              sat_a;
   logic                                              sat_b;

   dsp_route_regs #(.N_SLOTS(N_SLOTS)) u_regs (
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .sys_addr_i  (sys_addr_i),
      .sys_wdata_i (sys_wdata_i),
      .sys_wen_i   (sys_wen_i),
      .sys_ren_i   (sys_ren_i),
      .sys_rdata_o (sys_rdata_o),
      .sys_ack_o   (sys_ack_o),
      .src_dat_i   (src_dat),
      .sat_a_i     (sat_a),
      .sat_b_i     (sat_b),
      .in_sel_o    (in_sel),
      .out_sel_o   (out_sel)
   );

   signal_router #(.N_SLOTS(N_SLOTS)) u_router (
      .clk_i      (clk_i),
      .rstn_i     (rstn_i),
      .slot_dat_i (slot_dat_i),
      .asg1_i     (asg1_i),
      .asg2_i     (asg2_i),
      .adc_a_i    (adc_a_i),
      .adc_b_i    (adc_b_i),
      .dac_a_i    (dac_a_o),  // dac outputs loop back as sources
      .dac_b_i    (dac_b_o),
      .in_sel_i   (in_sel),
      .src_dat_o  (src_dat),
      .slot_in_o  (slot_in_o),
      .scope1_o   (scope1_o),
      .scope2_o   (scope2_o),
      .pwm0_o     (pwm0_o),
      .pwm1_o     (pwm1_o)
   );

   dac_sum_tree #(.N_SLOTS(N_SLOTS)) u_sum (
      .clk_i      (clk_i),
      .rstn_i     (rstn_i),
      .slot_dat_i (slot_dat_i),
      .asg1_i     (asg1_i),
      .asg2_i     (asg2_i),
      .out_sel_i  (out_sel),
      .dac_a_o    (dac_a_o),
      .dac_b_o    (dac_b_o),
      .sat_a_o    (sat_a),
      .sat_b_o    (sat_b)
   );

endmodule

/* sim/dsp_route_sva.sv */
module dsp_route_sva (
   input logic clk_i,
   input logic rstn_i,
   input logic wen_i,
   input logic ren_i,
   input logic ack_i
);

   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_cnt = 0;  // failed assertion count

   // each request answered on the next edge
   a_ack_after_req : assert property (@(posedge clk_i) disable iff (!rstn_i)
      (wen_i || ren_i) |=> ack_i)
      else begin
         fail_cnt++;
         $error("bus request not acknowledged on the next edge");
      end

   // ack held low through reset
   a_ack_low_in_reset : assert property (@(posedge clk_i) !rstn_i |=> !ack_i)
      else begin
         fail_cnt++;
         $error("acknowledge high during reset");
      end

   // idle cycle, so no ack one edge later
   a_no_ack_without_req : assert property (@(posedge clk_i) disable iff (!rstn_i)
      !(wen_i || ren_i) |=> !ack_i)
      else begin
         fail_cnt++;
         $error("acknowledge without a request in the cycle before");
      end

endmodule

bind dsp_route_top dsp_route_sva u_sva (
   .clk_i  (clk_i),
   .rstn_i (rstn_i),
   .wen_i  (sys_wen_i),
   .ren_i  (sys_ren_i),
   .ack_i  (sys_ack_o)
);

/* sim/tb_dsp_route.sv */
module tb_dsp_route
   import dsp_route_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int N_SLOTS      = 8;
   localparam int N_SINK       = N_SLOTS + 4;  // slots, scope 1/2, pwm 0/1
   localparam int N_DIR        = N_SLOTS + 2;  // slots and generators
   localparam int S_MAX        = 2 ** (DAT_W - 1) - 1;
   localparam int S_MIN        = -(2 ** (DAT_W - 1));
   localparam int ROUTE_ROUNDS = 100;
   localparam int MIX_ROUNDS   = 80;
   // reset, default reads, routing, readback, mixing, saturation, unmapped reads
   localparam int PLAN_CYC = 18 + 2 * N_CH + ROUTE_ROUNDS * 5 + 4 * N_CH
                           + (MIX_ROUNDS + 2) * (N_DIR + SUM_LATENCY + 4) + 2 * N_CH;
   localparam int TIMEOUT  = PLAN_CYC * 3 / 2;

   logic                     clk_i;
   logic                     rstn_i;
   logic [DAT_W-1:0]         adc_a_i;
   logic [DAT_W-1:0]         adc_b_i;
   logic [DAT_W-1:0]         asg1_i;
   logic [DAT_W-1:0]         asg2_i;
   logic [DAT_W-1:0]         dac_a_o;
   logic [DAT_W-1:0]         dac_b_o;
   logic [N_SLOTS*DAT_W-1:0] slot_dat_i;
   logic [N_SLOTS*DAT_W-1:0] slot_in_o;
   logic [DAT_W-1:0]         scope1_o;
   logic [DAT_W-1:0]         scope2_o;
   logic [DAT_W-1:0]         pwm0_o;
   logic [DAT_W-1:0]         pwm1_o;
   logic [31:0]              sys_addr_i;
   logic [31:0]              sys_wdata_i;
   logic                     sys_wen_i;
   logic                     sys_ren_i;
   logic [31:0]              sys_rdata_o;
   logic                     sys_ack_o;

   logic [SEL_W-1:0] in_sel_m  [N_SINK];  // model of the select registers
   out_sel_e         out_sel_m [N_DIR];
   logic [31:0]      lfsr = 32'h95e8;
   int               cycles;

   dsp_route_top #(.N_SLOTS(N_SLOTS)) u_dut (.*);

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;  // 20 ns period
   end

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr = lfsr_next(lfsr);  // one step per bit
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [DAT_W-1:0] direct_sample(input int c);
      if (c < N_SLOTS) begin
         return slot_dat_i[c*DAT_W +: DAT_W];
      end
      return (c == N_SLOTS) ? asg1_i : asg2_i;
   endfunction

   // unclamped sum of dac d where 0 is dac a
   function automatic int raw_sum(input int d);
      int s;
      s = 0;
      for (int c = 0; c < N_DIR; c++) begin
         if ((d == 0 && (out_sel_m[c] == OUT_A || out_sel_m[c] == OUT_BOTH)) ||
             (d == 1 && (out_sel_m[c] == OUT_B || out_sel_m[c] == OUT_BOTH))) begin
            s += int'($signed(direct_sample(c)));
         end
      end
      return s;
   endfunction

   function automatic logic clamps(input int s);
      return s > S_MAX || s < S_MIN;
   endfunction

   function automatic logic [DAT_W-1:0] dac_value(input int d);
      int s;
      s = raw_sum(d);
      if (s > S_MAX) begin
         s = S_MAX;
      end else if (s < S_MIN) begin
         s = S_MIN;
      end
      return DAT_W'(s);
   endfunction

   // sample behind a source code or zero for unused codes
   function automatic logic [DAT_W-1:0] src_value(input logic [SEL_W-1:0] code);
      int c;
      c = int'(code);
      if (c < N_DIR) begin
         return direct_sample(c);
      end
      case (c - N_DIR)
         0: return adc_a_i;
         1: return adc_b_i;
         2: return dac_value(0);  // dac feedback
         3: return dac_value(1);
         default: return '0;
      endcase
   endfunction

   task automatic check_sample(input logic [DAT_W-1:0] got, input logic [DAT_W-1:0] exp,
                               input string what);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
         $display("Test failed");
         $fatal(1, "stopped at first error");
      end
   endtask

   task automatic check_rdata(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s read %0h expected %0h", $time, what, got, exp);
         $display("Test failed");
         $fatal(1, "stopped at first error");
      end
   endtask

   task automatic check_flags(input logic [1:0] got, input logic [1:0] exp, input string what);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
         $display("Test failed");
         $fatal(1, "stopped at first error");
      end
   endtask

   // one access starting 2 ns after an edge and ending 2 ns after the ack edge
   task automatic bus_access(input logic wen, input logic [SEL_W-1:0] idx, input logic [15:0] off,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      sys_addr_i  = {12'h000, idx, off};
      sys_wdata_i = wdata;
      sys_wen_i   = wen;
      sys_ren_i   = !wen;
      @(posedge clk_i);
      #2;
      sys_wen_i = 1'b0;
      sys_ren_i = 1'b0;
      rdata     = sys_rdata_o;
      if (sys_ack_o !== 1'b1) begin
         $display("no acknowledge at %0t ns after access to offset %0h index %0d", $time, off, idx);
         $display("Test failed");
         $fatal(1, "missing acknowledge");
      end
   endtask

   task automatic write_insel(input logic [SEL_W-1:0] idx, input logic [SEL_W-1:0] code);
      logic [31:0] rd;
      bus_access(1'b1, idx, OFF_INSEL, (rand_bits(28) << SEL_W) | 32'(code), rd);
      if (idx < N_SINK) begin
         in_sel_m[idx] = code;  // others dropped
      end
   endtask

   task automatic write_outsel(input logic [SEL_W-1:0] idx, input out_sel_e sel);
      logic [31:0] rd;
      bus_access(1'b1, idx, OFF_OUTSEL, (rand_bits(30) << 2) | 32'(sel), rd);
      if (idx < N_DIR) begin
         out_sel_m[idx] = sel;
      end
   endtask

   task automatic read_check(input logic [SEL_W-1:0] idx, input logic [15:0] off,
                             input logic [31:0] exp, input string what);
      logic [31:0] rd;
      bus_access(1'b0, idx, off, rand_bits(32), rd);
      check_rdata(rd, exp, $sformatf("%s offset %0h index %0d", what, off, idx));
   endtask

   task automatic set_direct(input int c, input logic [DAT_W-1:0] v);
      if (c < N_SLOTS) begin
         slot_dat_i[c*DAT_W +: DAT_W] = v;
      end else if (c == N_SLOTS) begin
         asg1_i = v;
      end else begin
         asg2_i = v;
      end
   endtask

   task automatic drive_sources();
      adc_a_i = DAT_W'(rand_bits(DAT_W));
      adc_b_i = DAT_W'(rand_bits(DAT_W));
      for (int c = 0; c < N_DIR; c++) begin
         set_direct(c, DAT_W'(rand_bits(DAT_W)));
      end
   endtask

   task automatic check_sinks();
      for (int s = 0; s < N_SLOTS; s++) begin
         check_sample(slot_in_o[s*DAT_W +: DAT_W], src_value(in_sel_m[s]),
                      $sformatf("slot %0d input", s));
      end
      check_sample(scope1_o, src_value(in_sel_m[N_SLOTS]), "scope 1");
      check_sample(scope2_o, src_value(in_sel_m[N_SLOTS + 1]), "scope 2");
      check_sample(pwm0_o, src_value(in_sel_m[N_SLOTS + 2]), "pwm 0");
      check_sample(pwm1_o, src_value(in_sel_m[N_SLOTS + 3]), "pwm 1");
   endtask

   task automatic check_dacs();
      logic [31:0] rd;
      check_sample(dac_a_o, dac_value(0), "dac a");
      check_sample(dac_b_o, dac_value(1), "dac b");
      bus_access(1'b0, '0, OFF_SAT, '0, rd);
      check_flags(rd[1:0], {clamps(raw_sum(1)), clamps(raw_sum(0))}, "saturation flags");
      // dac feedback seen through the source table
      read_check(SEL_W'(N_DIR + 2), OFF_SIGNAL, 32'(dac_value(0)), "dac a feedback");
      read_check(SEL_W'(N_DIR + 3), OFF_SIGNAL, 32'(dac_value(1)), "dac b feedback");
   endtask

   initial begin
      cycles = 0;
      while (cycles < TIMEOUT) begin
         @(posedge clk_i);
         cycles++;
      end
      $display("timeout, the test did not finish within %0d cycles", TIMEOUT);
      $display("Test failed");
      $fatal(1, "timeout");
   end

   initial begin
      logic [31:0] exp;
      logic [15:0] off;
      int          mag;
      rstn_i      = 1'b0;
      sys_addr_i  = '0;
      sys_wdata_i = '0;
      sys_wen_i   = 1'b0;
      sys_ren_i   = 1'b0;
      adc_a_i     = '0;
      adc_b_i     = '0;
      asg1_i      = '0;
      asg2_i      = '0;
      slot_dat_i  = '0;
      for (int s = 0; s < N_SINK; s++) begin
         in_sel_m[s] = SEL_W'(N_SLOTS + 2);  // adc a
      end
      in_sel_m[N_SLOTS + 1] = SEL_W'(N_SLOTS + 3);  // scope 2 on adc b
      in_sel_m[N_SLOTS + 2] = SRC_NONE;
      in_sel_m[N_SLOTS + 3] = SRC_NONE;
      for (int c = 0; c < N_DIR; c++) begin
         out_sel_m[c] = OUT_OFF;
      end
      repeat (16) @(posedge clk_i);
      #2;
      rstn_i = 1'b1;

      // defaults seen on the sinks and in the registers
      drive_sources();
      repeat (2) @(posedge clk_i);
      #2;
      check_sinks();
      for (int i = 0; i < N_CH; i++) begin
         exp = (i < N_SINK) ? 32'(in_sel_m[i]) : '0;
         read_check(SEL_W'(i), OFF_INSEL, exp, "reset input select");
         exp = (i < N_DIR) ? 32'(OUT_OFF) : '0;
         read_check(SEL_W'(i), OFF_OUTSEL, exp, "reset output select");
      end

      // random routing with SRC_NONE and unused codes included
      repeat (ROUTE_ROUNDS) begin
         for (int w = 0; w < 3; w++) begin
            write_insel(SEL_W'(rand_bits(SEL_W)), SEL_W'(rand_bits(SEL_W)));
         end
         drive_sources();
         repeat (2) @(posedge clk_i);
         #2;
         check_sinks();
      end

      // sample readback while the sources are held
      repeat (4 * N_CH) begin
         exp = 32'(rand_bits(SEL_W));
         read_check(SEL_W'(exp), OFF_SIGNAL, 32'(src_value(SEL_W'(exp))), "source sample");
      end

      // random mixing
      repeat (MIX_ROUNDS) begin
         for (int c = 0; c < N_DIR; c++) begin
            write_outsel(SEL_W'(c), out_sel_e'(rand_bits(2)));
         end
         drive_sources();
         repeat (SUM_LATENCY + 1) @(posedge clk_i);
         #2;
         check_dacs();
      end

      // big same sign samples on one dac and small ones on the other
      for (int neg = 0; neg < 2; neg++) begin
         for (int c = 0; c < N_DIR; c++) begin
            if ((c % 2 == 0) == (neg == 0)) begin
               write_outsel(SEL_W'(c), OUT_A);
            end else begin
               write_outsel(SEL_W'(c), OUT_B);
            end
         end
         for (int c = 0; c < N_DIR; c++) begin
            mag = (1 << 12) + int'(rand_bits(12));
            if (c % 2 == 0) begin
               set_direct(c, DAT_W'(neg ? -mag : mag));
            end else begin
               set_direct(c, DAT_W'(int'(rand_bits(8)) - 128));  // small samples of either sign
            end
         end
         repeat (SUM_LATENCY + 1) @(posedge clk_i);
         #2;
         check_dacs();
      end

      // unmapped offsets read zero
      repeat (2 * N_CH) begin
         off = 16'(rand_bits(16));
         if (off == OFF_INSEL || off == OFF_OUTSEL || off == OFF_SAT || off == OFF_SIGNAL) begin
            off = off | 16'h0001;
         end
         read_check(SEL_W'(rand_bits(SEL_W)), off, '0, "unmapped");
      end

      if (u_dut.u_sva.fail_cnt == 0) begin
         $display("Test completed successfully");
         $finish;
      end else begin
         $display("%0d assertion checks on the bus acknowledge failed", u_dut.u_sva.fail_cnt);
         $display("Test failed");
         $fatal(1, "assertion failures");
      end
   end

endmodule

/* vlog.f */
source/dsp_route_pkg.sv
source/dsp_route_regs.sv
source/signal_router.sv
source/dac_sum_tree.sv
source/dsp_route_top.sv
sim/dsp_route_sva.sv
sim/tb_dsp_route.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the routing fabric testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_dsp_route \
   -f vlog.f -o tb_dsp_route > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

./obj_dir/tb_dsp_route > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Test failed" "$LOG"; then
   exit 1
fi
exit 0
